/* project.f */
src/csr_addr_pkg.sv
src/csr_field_pkg.sv
src/csr_decode.sv
src/csr_trap_ctrl.sv
src/csr_timer.sv
src/csr_save_bank.sv
src/csr_top.sv
verification/csr_properties.sv
verification/csr_tb.sv

/* run.sh */
#!/bin/sh
# build and run the csr testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module csr_tb -f project.f; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vcsr_tb 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q -F '*** TEST PASSED ***'; then
    exit 0
fi
echo "pass message not found"
exit 1

/* src/csr_addr_pkg.sv */
package csr_addr_pkg;

    // register and address widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 14;

    // kept csr addresses
    typedef enum logic [ADDR_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00C,
        // save register i lives at CSR_SAVE0 + i
        CSR_SAVE0  = 14'h030,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

endpackage

/* src/csr_decode.sv */
`timescale 1ns/1ps

module csr_decode #(
    parameter int NUM_SAVE = 4
) (
    input  logic                                            sw_en,
    input  logic                                            wen,
    input  logic [csr_addr_pkg::ADDR_W-1:0]                 addr,
    input  logic [csr_addr_pkg::DATA_W-1:0]                 crmd_q,
    input  logic [csr_addr_pkg::DATA_W-1:0]                 prmd_q,
    input  logic [csr_addr_pkg::DATA_W-1:0]                 ecfg_q,
    input  logic [csr_addr_pkg::DATA_W-1:0]                 estat_q,
    input  logic [csr_addr_pkg::DATA_W-1:0]                 era_q,
    input  logic [csr_addr_pkg::DATA_W-1:0]                 badv_q,
    input  logic [csr_addr_pkg::DATA_W-1:0]                 eentry_q,
    input  logic [csr_addr_pkg::DATA_W-1:0]                 tcfg_q,
    input  logic [csr_addr_pkg::DATA_W-1:0]                 tval_q,
    input  logic [csr_addr_pkg::DATA_W-1:0]                 tid_q,
    input  logic [NUM_SAVE-1:0][csr_addr_pkg::DATA_W-1:0]   save_q,
    output logic                                            crmd_we,
    output logic                                            prmd_we,
    output logic                                            ecfg_we,
    output logic                                            estat_we,
    output logic                                            era_we_sw,
    output logic                                            badv_we_sw,
    output logic                                            eentry_we,
    output logic                                            tcfg_we,
    output logic                                            ticlr_we,
    output logic [NUM_SAVE-1:0]                             save_we,
    output logic                                            tid_we,
    output logic [csr_addr_pkg::DATA_W-1:0]                 rdata
);
    import csr_addr_pkg::*;

    logic              wr;
    logic [ADDR_W-1:0] save_off;

    assign wr = sw_en & wen;
    // below CSR_SAVE0 this wraps high and matches no save slot
    assign save_off = addr - CSR_SAVE0;

    always_comb begin
        crmd_we    = 1'b0;
        prmd_we    = 1'b0;
        ecfg_we    = 1'b0;
        estat_we   = 1'b0;
        era_we_sw  = 1'b0;
        badv_we_sw = 1'b0;
        eentry_we  = 1'b0;
        tcfg_we    = 1'b0;
        ticlr_we   = 1'b0;
        tid_we     = 1'b0;
        save_we    = '0;
        rdata      = '0;
        case (addr)
            CSR_CRMD:   begin crmd_we    = wr; rdata = crmd_q;   end
            CSR_PRMD:   begin prmd_we    = wr; rdata = prmd_q;   end
            CSR_ECFG:   begin ecfg_we    = wr; rdata = ecfg_q;   end
            CSR_ESTAT:  begin estat_we   = wr; rdata = estat_q;  end
            CSR_ERA:    begin era_we_sw  = wr; rdata = era_q;    end
            CSR_BADV:   begin badv_we_sw = wr; rdata = badv_q;   end
            CSR_EENTRY: begin eentry_we  = wr; rdata = eentry_q; end
            CSR_TID:    begin tid_we     = wr; rdata = tid_q;    end
            CSR_TCFG:   begin tcfg_we    = wr; rdata = tcfg_q;   end
            CSR_TVAL:   rdata = tval_q;
            // ticlr is write only and reads back as zero
            CSR_TICLR:  ticlr_we = wr;
            default: begin
                for (int i = 0; i < NUM_SAVE; i++) begin
                    if (save_off == ADDR_W'(i)) begin
                        save_we[i] = wr;
                        rdata      = save_q[i];
                    end
                end
            end
        endcase
    end

endmodule

/* src/csr_field_pkg.sv */
package csr_field_pkg;

    // exception codes held in estat
    typedef enum logic [5:0] {
        ECODE_INT  = 6'h00,
        ECODE_SYS  = 6'h0B,
        ECODE_TLBR = 6'h3F
    } ecode_e;

    // interrupt status layout
    localparam int IS_W      = 13;
    localparam int HW_INT_W  = 8;
    localparam int HW_INT_LO = 2;
    localparam int TI_BIT    = 11;

    // estat code fields
    localparam int ESTAT_ECODE_LO   = 16;
    localparam int ESTAT_SUBCODE_LO = 22;
    localparam int ESTAT_SUBCODE_W  = 9;

    // crmd fields, prmd reuses the plv and ie positions
    localparam int CRMD_PLV_LO  = 0;
    localparam int CRMD_PLV_HI  = 1;
    localparam int CRMD_IE      = 2;
    localparam int CRMD_DA      = 3;
    localparam int CRMD_PG      = 4;
    localparam int CRMD_DATF_LO = 5;
    localparam int CRMD_DATF_HI = 6;
    localparam int CRMD_DATM_LO = 7;
    localparam int CRMD_DATM_HI = 8;

    // tcfg fields
    localparam int TCFG_EN         = 0;
    localparam int TCFG_PERIODIC   = 1;
    localparam int TCFG_INITVAL_LO = 2;
    localparam int TCFG_INITVAL_HI = 31;

    localparam logic [csr_addr_pkg::DATA_W-1:0] CRMD_RESET = 32'h0000_0008;

    // writable bits per register
    localparam logic [csr_addr_pkg::DATA_W-1:0] CRMD_MASK   = 32'h0000_01FF;
    localparam logic [csr_addr_pkg::DATA_W-1:0] PRMD_MASK   = 32'h0000_0007;
    localparam logic [csr_addr_pkg::DATA_W-1:0] ECFG_MASK   = 32'h0000_1FFF;
    localparam logic [csr_addr_pkg::DATA_W-1:0] ESTAT_MASK  = 32'h0000_0003;
    localparam logic [csr_addr_pkg::DATA_W-1:0] EENTRY_MASK = 32'hFFFF_FFC0;
    localparam logic [csr_addr_pkg::DATA_W-1:0] TCFG_MASK   = 32'hFFFF_FFFF;
    localparam logic [csr_addr_pkg::DATA_W-1:0] FULL_MASK   = 32'hFFFF_FFFF;

endpackage

/* src/csr_save_bank.sv */
`timescale 1ns/1ps

module csr_save_bank #(
    parameter int NUM_SAVE = 4
) (
    input  logic                                            clk,
    input  logic                                            aresetn,
    input  logic [csr_addr_pkg::DATA_W-1:0]                 wdata,
    input  logic [NUM_SAVE-1:0]                             save_we,
    input  logic                                            tid_we,
    output logic [NUM_SAVE-1:0][csr_addr_pkg::DATA_W-1:0]   save_q,
    output logic [csr_addr_pkg::DATA_W-1:0]                 tid_q
);
    import csr_field_pkg::*;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            save_q <= '0;
            tid_q  <= '0;
        end else begin
            // one-hot strobe, at most one slot per cycle
            for (int i = 0; i < NUM_SAVE; i++) begin
                if (save_we[i]) begin
                    save_q[i] <= wdata & FULL_MASK;
                end
            end
            if (tid_we) begin
                tid_q <= wdata & FULL_MASK;
            end
        end
    end

endmodule

/* src/csr_timer.sv */
`timescale 1ns/1ps

module csr_timer (
    input  logic                            clk,
    input  logic                            aresetn,
    input  logic [csr_addr_pkg::DATA_W-1:0] wdata,
    input  logic                            tcfg_we,
    input  logic                            ticlr_we,
    output logic [csr_addr_pkg::DATA_W-1:0] tcfg_q,
    output logic [csr_addr_pkg::DATA_W-1:0] tval_q,
    output logic                            timer_int
);
    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    logic [DATA_W-1:0] tcfg_wr;
    logic [DATA_W-1:0] reload_val;
    logic              expired;

    assign tcfg_wr = wdata & TCFG_MASK;
    // count starts at initval*4 + 1 so a zero initval still expires
    assign reload_val = {tcfg_q[TCFG_INITVAL_HI:TCFG_INITVAL_LO], 2'b01};

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg_q  <= '0;
            tval_q  <= '0;
            expired <= 1'b0;
        end else if (tcfg_we) begin
            tcfg_q  <= tcfg_wr;
            tval_q  <= {tcfg_wr[TCFG_INITVAL_HI:TCFG_INITVAL_LO], 2'b01};
            expired <= 1'b0;
        end else if (tval_q == '0) begin
            expired <= 1'b0;
            if (tcfg_q[TCFG_PERIODIC]) begin
                tval_q <= reload_val;
            end
        end else if (tcfg_q[TCFG_EN]) begin
            tval_q  <= tval_q - 1'b1;
            expired <= (tval_q == DATA_W'(1));
        end
    end

    // sticky until software clears it
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            timer_int <= 1'b0;
        end else if (ticlr_we) begin
            timer_int <= 1'b0;
        end else if (expired) begin
            timer_int <= 1'b1;
        end
    end

endmodule

/* src/csr_top.sv */
`timescale 1ns/1ps

module csr_top #(
    parameter int NUM_SAVE = 4
) (
    input  logic                                clk,
    input  logic                                aresetn,
    input  logic                                sw_en,
    input  logic                                wen,
    input  logic [csr_addr_pkg::ADDR_W-1:0]     addr,
    input  logic [csr_addr_pkg::DATA_W-1:0]     wdata,
    input  logic                                exception,
    input  logic                                ertn,
    input  logic                                tlb_refill,
    input  logic [6:0]                          ecode_in,
    input  logic                                ecode_we,
    input  logic                                era_we,
    input  logic                                badv_we,
    input  logic [csr_addr_pkg::DATA_W-1:0]     era_in,
    input  logic [csr_addr_pkg::DATA_W-1:0]     badv_in,
    input  logic [csr_field_pkg::HW_INT_W-1:0]  hw_int,
    output logic [csr_addr_pkg::DATA_W-1:0]     rdata,
    output logic [csr_addr_pkg::DATA_W-1:0]     crmd,
    output logic [csr_addr_pkg::DATA_W-1:0]     estat,
    output logic [csr_addr_pkg::DATA_W-1:0]     era,
    output logic [csr_addr_pkg::DATA_W-1:0]     eentry,
    output logic                                cpu_interrupt,
    output logic                                idle_over
);
    import csr_addr_pkg::*;

    // decoded write strobes
    logic crmd_we, prmd_we, ecfg_we, estat_we;
    logic era_we_sw, badv_we_sw, eentry_we;
    logic tcfg_we, ticlr_we, tid_we;
    logic [NUM_SAVE-1:0] save_we;

    // register values back to the read mux
    logic [DATA_W-1:0] prmd_q, ecfg_q, badv_q;
    logic [DATA_W-1:0] tcfg_q, tval_q, tid_q;
    logic [NUM_SAVE-1:0][DATA_W-1:0] save_q;
    logic timer_int;

    csr_decode #(.NUM_SAVE(NUM_SAVE)) u_decode (
        .sw_en(sw_en), .wen(wen), .addr(addr),
        .crmd_q(crmd), .prmd_q(prmd_q), .ecfg_q(ecfg_q), .estat_q(estat),
        .era_q(era), .badv_q(badv_q), .eentry_q(eentry),
        .tcfg_q(tcfg_q), .tval_q(tval_q), .tid_q(tid_q), .save_q(save_q),
        .crmd_we(crmd_we), .prmd_we(prmd_we), .ecfg_we(ecfg_we), .estat_we(estat_we),
        .era_we_sw(era_we_sw), .badv_we_sw(badv_we_sw), .eentry_we(eentry_we),
        .tcfg_we(tcfg_we), .ticlr_we(ticlr_we), .save_we(save_we), .tid_we(tid_we),
        .rdata(rdata)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk(clk), .aresetn(aresetn), .wdata(wdata),
        .crmd_we(crmd_we), .prmd_we(prmd_we), .ecfg_we(ecfg_we), .estat_we(estat_we),
        .era_we_sw(era_we_sw), .badv_we_sw(badv_we_sw), .eentry_we(eentry_we),
        .exception(exception), .ertn(ertn), .tlb_refill(tlb_refill),
        .ecode_in(ecode_in), .ecode_we(ecode_we),
        .era_in(era_in), .era_we(era_we), .badv_in(badv_in), .badv_we(badv_we),
        .hw_int(hw_int), .timer_int(timer_int),
        .crmd_q(crmd), .prmd_q(prmd_q), .ecfg_q(ecfg_q), .estat_q(estat),
        .era_q(era), .badv_q(badv_q), .eentry_q(eentry),
        .cpu_interrupt(cpu_interrupt), .idle_over(idle_over)
    );

    csr_timer u_timer (
        .clk(clk), .aresetn(aresetn), .wdata(wdata),
        .tcfg_we(tcfg_we), .ticlr_we(ticlr_we),
        .tcfg_q(tcfg_q), .tval_q(tval_q), .timer_int(timer_int)
    );

    csr_save_bank #(.NUM_SAVE(NUM_SAVE)) u_save_bank (
        .clk(clk), .aresetn(aresetn), .wdata(wdata),
        .save_we(save_we), .tid_we(tid_we),
        .save_q(save_q), .tid_q(tid_q)
    );

endmodule

/* src/csr_trap_ctrl.sv */
`timescale 1ns/1ps

module csr_trap_ctrl (
    input  logic                                clk,
    input  logic                                aresetn,
    input  logic [csr_addr_pkg::DATA_W-1:0]     wdata,
    input  logic                                crmd_we,
    input  logic                                prmd_we,
    input  logic                                ecfg_we,
    input  logic                                estat_we,
    input  logic                                era_we_sw,
    input  logic                                badv_we_sw,
    input  logic                                eentry_we,
    input  logic                                exception,
    input  logic                                ertn,
    input  logic                                tlb_refill,
    input  logic [6:0]                          ecode_in,
    input  logic                                ecode_we,
    input  logic [csr_addr_pkg::DATA_W-1:0]     era_in,
    input  logic                                era_we,
    input  logic [csr_addr_pkg::DATA_W-1:0]     badv_in,
    input  logic                                badv_we,
    input  logic [csr_field_pkg::HW_INT_W-1:0]  hw_int,
    input  logic                                timer_int,
    output logic [csr_addr_pkg::DATA_W-1:0]     crmd_q,
    output logic [csr_addr_pkg::DATA_W-1:0]     prmd_q,
    output logic [csr_addr_pkg::DATA_W-1:0]     ecfg_q,
    output logic [csr_addr_pkg::DATA_W-1:0]     estat_q,
    output logic [csr_addr_pkg::DATA_W-1:0]     era_q,
    output logic [csr_addr_pkg::DATA_W-1:0]     badv_q,
    output logic [csr_addr_pkg::DATA_W-1:0]     eentry_q,
    output logic                                cpu_interrupt,
    output logic                                idle_over
);
    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    logic [DATA_W-1:0]          crmd_wr;
    logic [DATA_W-1:0]          estat_wr;
    logic [1:0]                 soft_r;
    ecode_e                     ecode_r;
    logic [ESTAT_SUBCODE_W-1:0] subcode_r;
    logic [IS_W-1:0]            is_bits;

    // an equal pg/da pair is illegal, so the old translation mode is kept
    always_comb begin
        crmd_wr = wdata & CRMD_MASK;
        if (wdata[CRMD_PG] == wdata[CRMD_DA]) begin
            crmd_wr[CRMD_PG] = crmd_q[CRMD_PG];
            crmd_wr[CRMD_DA] = crmd_q[CRMD_DA];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd_q <= CRMD_RESET;
        end else if (ertn) begin
            crmd_q[CRMD_PLV_HI:CRMD_PLV_LO] <= prmd_q[CRMD_PLV_HI:CRMD_PLV_LO];
            crmd_q[CRMD_IE]                 <= prmd_q[CRMD_IE];
            // back from the refill handler into paged mode
            if (ecode_r == ECODE_TLBR) begin
                crmd_q[CRMD_DA] <= 1'b0;
                crmd_q[CRMD_PG] <= 1'b1;
            end
        end else if (exception) begin
            crmd_q[CRMD_PLV_HI:CRMD_PLV_LO] <= 2'b00;
            crmd_q[CRMD_IE]                 <= 1'b0;
            if (tlb_refill) begin
                crmd_q[CRMD_DA] <= 1'b1;
                crmd_q[CRMD_PG] <= 1'b0;
            end
        end else if (crmd_we) begin
            crmd_q <= crmd_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd_q <= '0;
        end else if (exception) begin
            prmd_q[CRMD_IE:CRMD_PLV_LO] <= crmd_q[CRMD_IE:CRMD_PLV_LO];
        end else if (prmd_we) begin
            prmd_q <= wdata & PRMD_MASK;
        end
    end

    // software only registers
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecfg_q   <= '0;
            eentry_q <= '0;
        end else begin
            if (ecfg_we) begin
                ecfg_q <= wdata & ECFG_MASK;
            end
            if (eentry_we) begin
                eentry_q <= wdata & EENTRY_MASK;
            end
        end
    end

    // hardware strobes win over software writes
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            era_q  <= '0;
            badv_q <= '0;
        end else begin
            if (era_we) begin
                era_q <= era_in;
            end else if (era_we_sw) begin
                era_q <= wdata & FULL_MASK;
            end
            if (badv_we) begin
                badv_q <= badv_in;
            end else if (badv_we_sw) begin
                badv_q <= wdata & FULL_MASK;
            end
        end
    end

    assign estat_wr = wdata & ESTAT_MASK;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            soft_r    <= '0;
            ecode_r   <= ECODE_INT;
            subcode_r <= '0;
        end else if (ecode_we) begin
            ecode_r   <= ecode_e'(ecode_in[5:0]);
            // subcode only means something for a nonzero code
            subcode_r <= (ecode_in[5:0] == ECODE_INT) ? '0 : ESTAT_SUBCODE_W'(ecode_in[6]);
        end else if (estat_we) begin
            soft_r <= estat_wr[1:0];
        end
    end

    always_comb begin
        is_bits                        = '0;
        is_bits[1:0]                   = soft_r;
        is_bits[HW_INT_LO +: HW_INT_W] = hw_int;
        is_bits[TI_BIT]                = timer_int;
    end

    always_comb begin
        estat_q                                        = '0;
        estat_q[IS_W-1:0]                              = is_bits;
        estat_q[ESTAT_ECODE_LO +: $bits(ecode_e)]      = ecode_r;
        estat_q[ESTAT_SUBCODE_LO +: ESTAT_SUBCODE_W]   = subcode_r;
    end

    assign cpu_interrupt = crmd_q[CRMD_IE] & (|(ecfg_q[IS_W-1:0] & is_bits));
    // any pending source wakes the core, enabled or not
    assign idle_over     = |is_bits;

endmodule

/* verification/csr_properties.sv */
`timescale 1ns/1ps

module csr_properties (
    input logic                            clk,
    input logic                            aresetn,
    input logic                            exception,
    input logic                            ertn,
    input logic [csr_addr_pkg::DATA_W-1:0] crmd_q,
    input logic                            cpu_interrupt
);
    import csr_field_pkg::*;

    // exactly one translation mode is active
    pg_da_differ: assert property (@(posedge clk) disable iff (!aresetn)
        crmd_q[CRMD_PG] != crmd_q[CRMD_DA])
        else $error("crmd pg and da are equal");

    exception_clears_plv_ie: assert property (@(posedge clk) disable iff (!aresetn)
        (exception && !ertn) |=> (crmd_q[CRMD_IE:CRMD_PLV_LO] == 3'b000))
        else $error("plv or ie not cleared after exception");

    irq_needs_ie: assert property (@(posedge clk) disable iff (!aresetn)
        cpu_interrupt |-> crmd_q[CRMD_IE])
        else $error("cpu_interrupt raised with ie clear");

endmodule

bind csr_trap_ctrl csr_properties u_properties (
    .clk(clk),
    .aresetn(aresetn),
    .exception(exception),
    .ertn(ertn),
    .crmd_q(crmd_q),
    .cpu_interrupt(cpu_interrupt)
);

/* verification/csr_tb.sv */
`timescale 1ns/1ps

module csr_tb;
    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    localparam int NUM_SAVE    = 4;
    localparam int CLK_PERIOD  = 10;
    localparam int TEST_CYCLES = 400;
    localparam int MAX_INITVAL = 3;
    // longest wait for one timer interrupt plus some margin
    localparam int TIMER_WAIT  = 2 * (4 * MAX_INITVAL + 2) + 8;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 4 * TIMER_WAIT) * CLK_PERIOD;

    logic                clk;
    logic                aresetn;
    logic                sw_en;
    logic                wen;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
    logic                exception;
    logic                ertn;
    logic                tlb_refill;
    logic [6:0]          ecode_in;
    logic                ecode_we;
    logic                era_we;
    logic                badv_we;
    logic [DATA_W-1:0]   era_in;
    logic [DATA_W-1:0]   badv_in;
    logic [HW_INT_W-1:0] hw_int;
    logic [DATA_W-1:0]   rdata;
    logic [DATA_W-1:0]   crmd;
    logic [DATA_W-1:0]   estat;
    logic [DATA_W-1:0]   era;
    logic [DATA_W-1:0]   eentry;
    logic                cpu_interrupt;
    logic                idle_over;

    // shadow copy of the register file
    logic [DATA_W-1:0]   sh_crmd, sh_prmd, sh_ecfg, sh_era, sh_badv, sh_eentry;
    logic [DATA_W-1:0]   sh_tcfg, sh_tval, sh_tid;
    logic [DATA_W-1:0]   sh_save [NUM_SAVE];
    logic [1:0]          sh_soft;
    logic [5:0]          sh_ecode;
    logic                sh_sub;
    logic                sh_ti;

    integer              seed;
    string               test_name;
    logic [ADDR_W-1:0]   wr_addrs [$];

    csr_top #(.NUM_SAVE(NUM_SAVE)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [DATA_W-1:0] mask_of(input logic [ADDR_W-1:0] a);
        case (a)
            CSR_CRMD:   return CRMD_MASK;
            CSR_PRMD:   return PRMD_MASK;
            CSR_ECFG:   return ECFG_MASK;
            CSR_ESTAT:  return ESTAT_MASK;
            CSR_EENTRY: return EENTRY_MASK;
            CSR_TCFG:   return TCFG_MASK;
            default:    return FULL_MASK;
        endcase
    endfunction

    function automatic logic is_save(input logic [ADDR_W-1:0] a);
        return (a >= CSR_SAVE0) && (a < CSR_SAVE0 + NUM_SAVE);
    endfunction

    function automatic logic [IS_W-1:0] pending_bits();
        logic [IS_W-1:0] p;
        p                              = '0;
        p[1:0]                         = sh_soft;
        p[HW_INT_LO +: HW_INT_W]       = hw_int;
        p[TI_BIT]                      = sh_ti;
        return p;
    endfunction

    function automatic logic expected_irq();
        return sh_crmd[CRMD_IE] & (|(sh_ecfg[IS_W-1:0] & pending_bits()));
    endfunction

    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] a);
        logic [DATA_W-1:0] v;
        v = '0;
        case (a)
            CSR_CRMD:   v = sh_crmd;
            CSR_PRMD:   v = sh_prmd;
            CSR_ECFG:   v = sh_ecfg;
            CSR_ESTAT: begin
                v[IS_W-1:0] = pending_bits();
                v[21:16]    = sh_ecode;
                v[22]       = sh_sub;
            end
            CSR_ERA:    v = sh_era;
            CSR_BADV:   v = sh_badv;
            CSR_EENTRY: v = sh_eentry;
            CSR_TID:    v = sh_tid;
            CSR_TCFG:   v = sh_tcfg;
            CSR_TVAL:   v = sh_tval;
            default: begin
                if (is_save(a)) begin
                    v = sh_save[a - CSR_SAVE0];
                end
            end
        endcase
        return v;
    endfunction

    task automatic model_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] v;
        v = d & mask_of(a);
        case (a)
            CSR_CRMD: begin
                // an equal pg/da pair leaves the translation mode alone
                if (d[CRMD_PG] == d[CRMD_DA]) begin
                    v[CRMD_PG] = sh_crmd[CRMD_PG];
                    v[CRMD_DA] = sh_crmd[CRMD_DA];
                end
                sh_crmd = v;
            end
            CSR_PRMD:   sh_prmd   = v;
            CSR_ECFG:   sh_ecfg   = v;
            CSR_ESTAT:  sh_soft   = v[1:0];
            CSR_ERA:    sh_era    = v;
            CSR_BADV:   sh_badv   = v;
            CSR_EENTRY: sh_eentry = v;
            CSR_TID:    sh_tid    = v;
            CSR_TCFG: begin
                sh_tcfg = v;
                sh_tval = (v >> TCFG_INITVAL_LO) * 4 + 1;
            end
            CSR_TICLR:  sh_ti = 1'b0;
            default: begin
                if (is_save(a)) begin
                    sh_save[a - CSR_SAVE0] = v;
                end
            end
        endcase
    endtask

    task automatic report_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_val(input string what, input logic [DATA_W-1:0] exp_v,
                             input logic [DATA_W-1:0] act_v);
        assert (act_v === exp_v) else begin
            $display("** Error [%s] %s: expected %h, actual %h",
                     test_name, what, exp_v, act_v);
            report_failure();
        end
    endtask

    task automatic sw_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        @(posedge clk);
        sw_en <= 1'b1;
        wen   <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        wen   <= 1'b0;
        model_write(a, d);
    endtask

    // a write cycle with sw_en low that the DUT must ignore
    task automatic blocked_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        @(posedge clk);
        sw_en <= 1'b0;
        wen   <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        wen   <= 1'b0;
    endtask

    task automatic check_reg(input logic [ADDR_W-1:0] a);
        @(posedge clk);
        sw_en <= 1'b1;
        wen   <= 1'b0;
        addr  <= a;
        @(negedge clk);
        check_val($sformatf("read of csr 0x%h", a), expected_read(a), rdata);
    endtask

    task automatic trap_event(input logic exc, input logic ret, input logic refill,
                              input logic [6:0] code);
        logic [DATA_W-1:0] era_v;
        logic [DATA_W-1:0] badv_v;
        era_v  = $random(seed);
        badv_v = $random(seed);
        @(posedge clk);
        exception  <= exc;
        ertn       <= ret;
        tlb_refill <= refill;
        ecode_in   <= code;
        ecode_we   <= exc;
        era_in     <= era_v;
        era_we     <= exc;
        badv_in    <= badv_v;
        badv_we    <= exc;
        @(posedge clk);
        exception  <= 1'b0;
        ertn       <= 1'b0;
        tlb_refill <= 1'b0;
        ecode_we   <= 1'b0;
        era_we     <= 1'b0;
        badv_we    <= 1'b0;
        // ertn outranks exception
        if (ret) begin
            sh_crmd[CRMD_IE:CRMD_PLV_LO] = sh_prmd[CRMD_IE:CRMD_PLV_LO];
            if (sh_ecode == ECODE_TLBR) begin
                sh_crmd[CRMD_DA] = 1'b0;
                sh_crmd[CRMD_PG] = 1'b1;
            end
        end else if (exc) begin
            sh_prmd[CRMD_IE:CRMD_PLV_LO] = sh_crmd[CRMD_IE:CRMD_PLV_LO];
            sh_crmd[CRMD_IE:CRMD_PLV_LO] = 3'b000;
            if (refill) begin
                sh_crmd[CRMD_DA] = 1'b1;
                sh_crmd[CRMD_PG] = 1'b0;
            end
        end
        if (exc) begin
            sh_ecode = code[5:0];
            sh_sub   = (code[5:0] != 6'h00) & code[6];
            sh_era   = era_v;
            sh_badv  = badv_v;
        end
    endtask

    // counts cycles from the end of the last write until estat shows the timer bit
    task automatic wait_timer(input int limit, output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!estat[TI_BIT] && cycles <= limit) begin
            cycles++;
            @(negedge clk);
        end
        if (!estat[TI_BIT]) begin
            $display("timer interrupt did not arrive within %0d cycles in %s",
                     limit, test_name);
            report_failure();
        end else begin
            sh_ti = 1'b1;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the test did not finish", WATCHDOG_NS);
        report_failure();
    end

    initial begin
        logic [DATA_W-1:0] d;
        logic [DATA_W-1:0] v;
        int                cycles;

        seed       = 32'hde9d_b4c9;
        aresetn    = 1'b0;
        sw_en      = 1'b0;
        wen        = 1'b0;
        addr       = '0;
        wdata      = '0;
        exception  = 1'b0;
        ertn       = 1'b0;
        tlb_refill = 1'b0;
        ecode_in   = '0;
        ecode_we   = 1'b0;
        era_we     = 1'b0;
        badv_we    = 1'b0;
        era_in     = '0;
        badv_in    = '0;
        hw_int     = '0;
        sh_crmd    = CRMD_RESET;
        {sh_prmd, sh_ecfg, sh_era, sh_badv, sh_eentry} = '0;
        {sh_tcfg, sh_tval, sh_tid} = '0;
        foreach (sh_save[i]) sh_save[i] = '0;
        {sh_soft, sh_ecode, sh_sub, sh_ti} = '0;

        wr_addrs = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA,
                     CSR_BADV, CSR_EENTRY, CSR_TID, CSR_TCFG};
        for (int i = 0; i < NUM_SAVE; i++) begin
            wr_addrs.push_back(ADDR_W'(CSR_SAVE0 + i));
        end

        repeat (5) @(posedge clk);
        aresetn <= 1'b1;

        test_name = "reset values";
        foreach (wr_addrs[i]) check_reg(wr_addrs[i]);
        check_reg(CSR_TVAL);
        check_reg(CSR_TICLR);
        check_reg(14'h3FF);
        check_reg(14'h002);

        test_name = "masked write";
        foreach (wr_addrs[i]) begin
            d = $random(seed);
            // keep the timer stopped here
            if (wr_addrs[i] == CSR_TCFG) d[TCFG_EN] = 1'b0;
            sw_write(wr_addrs[i], d);
            check_reg(wr_addrs[i]);
        end
        check_val("eentry output", sh_eentry, eentry);
        check_reg(CSR_TVAL);

        test_name = "write with sw_en low";
        foreach (wr_addrs[i]) blocked_write(wr_addrs[i], $random(seed));
        foreach (wr_addrs[i]) check_reg(wr_addrs[i]);
        check_reg(CSR_TVAL);

        test_name = "crmd mode";
        sw_write(CSR_CRMD, 32'h0000_00D1);
        check_reg(CSR_CRMD);
        // pg = da = 1 keeps the mode while the other fields still land
        sw_write(CSR_CRMD, 32'h0000_013E);
        check_reg(CSR_CRMD);
        check_val("crmd with pg and da kept", 32'h0000_0136, crmd);
        sw_write(CSR_CRMD, 32'h0000_01C3);
        check_reg(CSR_CRMD);
        sw_write(CSR_CRMD, 32'h0000_0008);
        check_reg(CSR_CRMD);
        repeat (8) begin
            sw_write(CSR_CRMD, $random(seed));
            check_reg(CSR_CRMD);
        end

        test_name = "exception and return";
        sw_write(CSR_CRMD, 32'h0000_0017);
        sw_write(CSR_PRMD, 32'h0);
        trap_event(1'b1, 1'b0, 1'b0, {1'b1, ECODE_SYS});
        @(negedge clk);
        check_val("crmd after exception", 32'h0000_0010, crmd);
        check_reg(CSR_PRMD);
        check_reg(CSR_ESTAT);
        check_reg(CSR_ERA);
        check_val("era output", sh_era, era);
        check_reg(CSR_BADV);
        trap_event(1'b0, 1'b1, 1'b0, 7'h00);
        check_reg(CSR_CRMD);

        test_name = "tlb refill";
        trap_event(1'b1, 1'b0, 1'b1, {1'b1, ECODE_TLBR});
        @(negedge clk);
        check_val("crmd after refill", 32'h0000_0008, crmd);
        check_reg(CSR_ESTAT);
        trap_event(1'b0, 1'b1, 1'b0, 7'h00);
        @(negedge clk);
        check_val("crmd after refill return", 32'h0000_0017, crmd);
        check_reg(CSR_CRMD);

        test_name = "timer one-shot";
        sw_write(CSR_ESTAT, 32'h0);
        sw_write(CSR_ECFG, 32'h1 << TI_BIT);
        sw_write(CSR_TCFG, (MAX_INITVAL << TCFG_INITVAL_LO) | (1 << TCFG_EN));
        wait_timer(TIMER_WAIT, cycles);
        check_val("cycles to interrupt", 4 * MAX_INITVAL + 2, cycles);
        check_val("cpu_interrupt", {31'd0, expected_irq()}, {31'd0, cpu_interrupt});
        sh_tval = '0;
        check_reg(CSR_ESTAT);
        check_reg(CSR_TVAL);
        sw_write(CSR_TICLR, 32'h0);
        @(negedge clk);
        check_val("cpu_interrupt after clear", 32'd0, {31'd0, cpu_interrupt});
        check_reg(CSR_ESTAT);

        test_name = "timer periodic";
        sw_write(CSR_TCFG, (2 << TCFG_INITVAL_LO) | (1 << TCFG_PERIODIC) | (1 << TCFG_EN));
        wait_timer(TIMER_WAIT, cycles);
        check_val("cycles to first interrupt", 4 * 2 + 2, cycles);
        sw_write(CSR_TICLR, 32'h0);
        wait_timer(TIMER_WAIT, cycles);
        sw_write(CSR_TICLR, 32'h0);
        sw_write(CSR_TCFG, 32'h0);
        check_reg(CSR_ESTAT);
        check_reg(CSR_TVAL);

        test_name = "hardware interrupt";
        sw_write(CSR_ECFG, 32'h0);
        v = $random(seed);
        @(posedge clk);
        hw_int <= v[HW_INT_W-1:0] | 8'h01;
        @(negedge clk);
        check_val("estat hw bits", {24'd0, v[HW_INT_W-1:0] | 8'h01}, {24'd0, estat[9:2]});
        check_val("idle_over", 32'd1, {31'd0, idle_over});
        check_val("cpu_interrupt masked", {31'd0, expected_irq()}, {31'd0, cpu_interrupt});
        sw_write(CSR_ECFG, 32'h1 << HW_INT_LO);
        @(negedge clk);
        check_val("cpu_interrupt enabled", 32'd1, {31'd0, cpu_interrupt});
        sw_write(CSR_CRMD, sh_crmd & ~(32'h1 << CRMD_IE));
        @(negedge clk);
        check_val("cpu_interrupt with ie clear", {31'd0, expected_irq()}, {31'd0, cpu_interrupt});
        check_reg(CSR_ESTAT);
        @(posedge clk);
        hw_int <= '0;
        @(negedge clk);
        check_val("idle_over cleared", 32'd0, {31'd0, idle_over});

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
